//--- Makefile
# Verilator build and run for the integer register pipeline.
# Any variable below can be overridden on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_x86_int_pipe
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+.
x86_regs_pkg.sv
x86_stage_ifs.sv
x86_gpr_file.sv
x86_operand_read.sv
x86_execute.sv
x86_int_pipe.sv
tb_x86_int_pipe.sv

//--- tb_x86_int_pipe.sv
/*
 * Directed testbench for the integer register pipeline.
 * Keeps its own register model and checks retire outputs and the debug port.
 */
`default_nettype none

`include "x86_core_settings.svh"

module tb_x86_int_pipe;
    timeunit 1ns;
    timeprecision 100ps;

    import x86_regs_pkg::*;

    logic     clk;
    logic     rst_n;
    logic     issue_valid;
    alu_op_t  issue_op;
    op_size_t issue_size;
    reg_num_t issue_dst;
    reg_num_t issue_src;
    reg_num_t issue_base;
    reg_num_t issue_index;
    scale_t   issue_scale;
    word_t    issue_disp;
    logic     retire_valid;
    reg_num_t retire_dst;
    op_size_t retire_size;
    word_t    retire_value;
    word_t    retire_addr;
    reg_num_t dbg_reg;
    word_t    dbg_value;

    word_t model [8];
    word_t lcg_state = 32'd1;
    int    checks = 0;
    int    errors = 0;

    x86_int_pipe x86_int_pipe_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // reference model and random numbers
    // --------------------------------------------------
    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t size_mask(input op_size_t size);
        case (size)
            `SIZE_16: return 32'h0000_ffff;
            `SIZE_8:  return 32'h0000_00ff;
            default:  return 32'hffff_ffff;
        endcase
    endfunction

    // ah..bh live in registers 0..3
    function automatic reg_num_t home_reg(input reg_num_t num, input op_size_t size);
        return (size == `SIZE_8) ? {1'b0, num[1:0]} : num;
    endfunction

    function automatic int byte_shift(input reg_num_t num, input op_size_t size);
        return (size == `SIZE_8 && num[2]) ? 8 : 0;
    endfunction

    function automatic word_t model_read(input reg_num_t num, input op_size_t size);
        return (model[home_reg(num, size)] >> byte_shift(num, size)) & size_mask(size);
    endfunction

    function automatic void model_write(input reg_num_t num, input op_size_t size,
                                        input word_t data);
        reg_num_t r;
        word_t    mask;
        r = home_reg(num, size);
        mask = size_mask(size) << byte_shift(num, size);
        model[r] = (model[r] & ~mask) | ((data << byte_shift(num, size)) & mask);
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_num(input string what, input reg_num_t got, input reg_num_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_size(input string what, input op_size_t got, input op_size_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - start);
        end
    endtask

    // --------------------------------------------------
    // drivers
    // --------------------------------------------------
    task automatic drive_issue(input alu_op_t op, input op_size_t size, input reg_num_t dst,
                               input reg_num_t src, input reg_num_t base,
                               input reg_num_t index, input scale_t scale, input word_t disp);
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_size  <= size;
        issue_dst   <= dst;
        issue_src   <= src;
        issue_base  <= base;
        issue_index <= index;
        issue_scale <= scale;
        issue_disp  <= disp;
    endtask

    task automatic read_dbg(input reg_num_t r, output word_t value);
        @(posedge clk);
        dbg_reg <= r;
        @(negedge clk);
        value = dbg_value;
    endtask

    task automatic issue_and_wait(input alu_op_t op, input op_size_t size, input reg_num_t dst,
                                  input reg_num_t src, input reg_num_t base,
                                  input reg_num_t index, input scale_t scale,
                                  input word_t disp, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        @(posedge clk);
        drive_issue(op, size, dst, src, base, index, scale, disp);
        @(posedge clk);
        issue_valid <= 1'b0;
        while (!ok && waited < `TB_TIMEOUT_CYCLES) begin
            @(negedge clk);
            ok = retire_valid;
            waited++;
        end
        if (!ok) begin
            $display("timeout waiting for retire");
            errors++;
        end
    endtask

    // one instruction, checked at retire and again in the register file
    task automatic run_op(input alu_op_t op, input op_size_t size, input reg_num_t dst,
                          input reg_num_t src, input reg_num_t base, input reg_num_t index,
                          input scale_t scale, input word_t disp);
        word_t    op1;
        word_t    op2;
        word_t    addr;
        word_t    result;
        word_t    got;
        logic     ok;
        op1 = model_read(dst, size);
        op2 = model_read(src, size);
        addr = model[base] + (model[index] << scale) + disp;
        case (op)
            `ALU_MOV: result = op2;
            `ALU_ADD: result = op1 + op2;
            `ALU_SUB: result = op1 - op2;
            default:  result = addr;
        endcase
        result = result & size_mask(size);
        issue_and_wait(op, size, dst, src, base, index, scale, disp, ok);
        if (ok) begin
            check_word("retire_value", retire_value, result);
            check_reg_num("retire_dst", retire_dst, dst);
            check_size("retire_size", retire_size, size);
            check_word("retire_addr", retire_addr, addr);
            model_write(dst, size, result);
            read_dbg(home_reg(dst, size), got);
            check_word("register after write", got, model[home_reg(dst, size)]);
        end
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_reset();
        int    start;
        word_t got;
        start = errors;
        for (int i = 0; i < 8; i++) begin
            model[i] = (i == 4) ? `GPR_RESET_ESP : 32'h0;
            read_dbg(reg_num_t'(i), got);
            check_word("reset value", got, model[i]);
        end
        repeat (3) begin
            @(negedge clk);
            check_bit("idle retire_valid", retire_valid, 1'b0);
        end
        report_test("reset state", start);
    endtask

    task automatic test_arith32();
        int    start;
        word_t r;
        start = errors;
        // seed every register with a random displacement
        for (int i = 0; i < 8; i++) begin
            run_op(`ALU_LEA, `SIZE_32, reg_num_t'(i), 3'd0, reg_num_t'(i), reg_num_t'(i),
                   2'd0, lcg_next());
        end
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            run_op(alu_op_t'(r[31:16] % 16'd3), `SIZE_32, r[30:28], r[26:24], 3'd0, 3'd0,
                   2'd0, 32'h0);
        end
        report_test("32-bit arithmetic", start);
    endtask

    task automatic test_partial();
        int start;
        start = errors;
        for (int i = 0; i < 8; i++) begin
            run_op(`ALU_MOV, `SIZE_16, reg_num_t'(i), reg_num_t'(7 - i), 3'd0, 3'd0, 2'd0, 0);
            run_op(`ALU_MOV, `SIZE_8, reg_num_t'(i), reg_num_t'(i + 5), 3'd0, 3'd0, 2'd0, 0);
            run_op(`ALU_ADD, `SIZE_8, reg_num_t'(i), reg_num_t'(i + 2), 3'd0, 3'd0, 2'd0, 0);
            run_op(`ALU_SUB, `SIZE_16, reg_num_t'(i), reg_num_t'(i + 1), 3'd0, 3'd0, 2'd0, 0);
        end
        report_test("partial writes", start);
    endtask

    task automatic test_lea();
        int    start;
        word_t r;
        start = errors;
        for (int s = 0; s < 4; s++) begin
            for (int j = 0; j < 3; j++) begin
                r = lcg_next();
                run_op(`ALU_LEA, op_size_t'((s + j) % 3), r[31:29], 3'd0, r[27:25], r[23:21],
                       scale_t'(s), lcg_next());
            end
        end
        report_test("effective address", start);
    endtask

    task automatic test_burst();
        int    start;
        int    retired;
        word_t expected [4];
        word_t got;
        start = errors;
        retired = 0;
        for (int k = 0; k < 4; k++) begin
            expected[k] = model[k] + model[k + 4];
        end
        // issue k is driven in loop cycle k and must retire in cycle k + 2
        for (int cyc = 0; cyc < 4 + `TB_TIMEOUT_CYCLES && retired < 4; cyc++) begin
            @(posedge clk);
            if (cyc < 4) begin
                drive_issue(`ALU_ADD, `SIZE_32, reg_num_t'(cyc), reg_num_t'(cyc + 4),
                            3'd0, 3'd0, 2'd0, 32'h0);
            end else begin
                issue_valid <= 1'b0;
            end
            @(negedge clk);
            if (retire_valid) begin
                if (cyc != retired + 2) begin
                    errors++;
                    $display("Fail at %0t: burst retire %0d in cycle %0d, expected %0d",
                             $time, retired, cyc, retired + 2);
                end
                check_reg_num("burst retire_dst", retire_dst, reg_num_t'(retired));
                check_word("burst retire_value", retire_value, expected[retired]);
                retired++;
            end
        end
        if (retired < 4) begin
            $display("timeout waiting for retire");
            errors++;
        end
        for (int k = 0; k < 4; k++) begin
            model[k] = expected[k];
            read_dbg(reg_num_t'(k), got);
            check_word("burst register", got, model[k]);
        end
        report_test("pipelined burst", start);
    endtask

    initial begin
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue_op = `ALU_MOV;
        issue_size = `SIZE_32;
        issue_dst = 3'd0;
        issue_src = 3'd0;
        issue_base = 3'd0;
        issue_index = 3'd0;
        issue_scale = 2'd0;
        issue_disp = 32'h0;
        dbg_reg = 3'd0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_arith32();
        test_partial();
        test_lea();
        test_burst();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- x86_core_settings.svh
/*
 * Architectural constants for the integer pipeline.
 * Include wherever size codes, ALU op codes or reset values are needed.
 */
`ifndef X86_CORE_SETTINGS_SVH
`define X86_CORE_SETTINGS_SVH

// operand size codes, code 3 is reserved
`define SIZE_32 2'd0
`define SIZE_16 2'd1
`define SIZE_8  2'd2

// ALU operation codes
`define ALU_MOV 2'd0
`define ALU_ADD 2'd1
`define ALU_SUB 2'd2
`define ALU_LEA 2'd3

// esp comes out of reset pointing at the top of the stack
`define GPR_RESET_ESP 32'h0000_fff0

`define TB_TIMEOUT_CYCLES 20

`endif

//--- x86_execute.sv
/*
 * Second pipeline stage. Computes mov, add, sub or lea on the operands
 * from the read stage, truncates to the operand size and registers the
 * result. The registered result is both the retire output and the writeback.
 */
`default_nettype none

`include "x86_core_settings.svh"

module x86_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    exec_if.consumer                ex,
    gpr_write_if.writer             wr,
    output logic                    retire_valid,
    output x86_regs_pkg::reg_num_t  retire_dst,
    output x86_regs_pkg::op_size_t  retire_size,
    output x86_regs_pkg::word_t     retire_value,
    output x86_regs_pkg::word_t     retire_addr
);
    import x86_regs_pkg::*;

    word_t scaled_index;
    word_t eff_addr;
    word_t alu_result;
    word_t sized_result;

    // --------------------------------------------------
    // full-width effective address
    // --------------------------------------------------
    assign scaled_index = ex.index << ex.scale;
    assign eff_addr     = ex.base + scaled_index + ex.disp;

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb begin
        case (ex.alu_op)
            `ALU_MOV: alu_result = ex.op2;
            `ALU_ADD: alu_result = ex.op1 + ex.op2;
            `ALU_SUB: alu_result = ex.op1 - ex.op2;
            // ALU_LEA
            default:  alu_result = eff_addr;
        endcase
    end

    // drop the bits above the operand size
    always_comb begin
        case (ex.size)
            `SIZE_16: sized_result = {16'h0, alu_result[15:0]};
            `SIZE_8:  sized_result = {24'h0, alu_result[7:0]};
            default:  sized_result = alu_result;
        endcase
    end

    // --------------------------------------------------
    // retire registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_dst   <= ex.dst;
        retire_size  <= ex.size;
        retire_value <= sized_result;
        retire_addr  <= eff_addr;
    end

    // writeback lands in the file one edge after retire
    assign wr.wb_en   = retire_valid;
    assign wr.wb_reg  = retire_dst;
    assign wr.wb_size = retire_size;
    assign wr.wb_data = retire_value;

endmodule

`default_nettype wire

//--- x86_gpr_file.sv
/*
 * Eight general registers eax..edi with sized operand reads,
 * full-width SIB and debug reads, and a sized read-merge-write port.
 * Writes land on the clock edge; all reads are combinational.
 */
`default_nettype none

`include "x86_core_settings.svh"

module x86_gpr_file (
    input  logic                   clk,
    input  logic                   rst_n,
    gpr_read_if.file               rd,
    gpr_write_if.file              wr,
    input  x86_regs_pkg::reg_num_t dbg_reg,
    output x86_regs_pkg::word_t    dbg_value
);
    import x86_regs_pkg::*;

    localparam reg_num_t ESP_NUM = 3'd4;

    word_t    gpr [8];
    reg_num_t op1_phys;
    reg_num_t op2_phys;
    reg_num_t wb_phys;

    // --------------------------------------------------
    // register number mapping
    // --------------------------------------------------

    // at 8 bits, 4..7 are the high bytes of registers 0..3
    function automatic reg_num_t phys_reg(input reg_num_t num, input op_size_t size);
        if (size == `SIZE_8) begin
            return {1'b0, num[1:0]};
        end
        return num;
    endfunction

    // sized view of a full register, zero extended
    function automatic word_t sized_view(input word_t full, input reg_num_t num,
                                         input op_size_t size);
        case (size)
            `SIZE_16: return {16'h0, full[15:0]};
            `SIZE_8: begin
                if (num[2]) begin
                    return {24'h0, full[15:8]};
                end
                return {24'h0, full[7:0]};
            end
            default: return full;
        endcase
    endfunction

    // merge sized data into the old register contents
    function automatic word_t merge(input word_t old, input word_t data, input reg_num_t num,
                                    input op_size_t size);
        case (size)
            `SIZE_16: return {old[31:16], data[15:0]};
            `SIZE_8: begin
                if (num[2]) begin
                    return {old[31:16], data[7:0], old[7:0]};
                end
                return {old[31:8], data[7:0]};
            end
            default: return data;
        endcase
    endfunction

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    assign op1_phys = phys_reg(rd.op1_reg, rd.read_size);
    assign op2_phys = phys_reg(rd.op2_reg, rd.read_size);

    assign rd.op1_value   = sized_view(gpr[op1_phys], rd.op1_reg, rd.read_size);
    assign rd.op2_value   = sized_view(gpr[op2_phys], rd.op2_reg, rd.read_size);

    // SIB registers are always full width
    assign rd.base_value  = gpr[rd.base_reg];
    assign rd.index_value = gpr[rd.index_reg];

    assign dbg_value = gpr[dbg_reg];

    // --------------------------------------------------
    // writeback
    // --------------------------------------------------
    assign wb_phys = phys_reg(wr.wb_reg, wr.wb_size);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                gpr[i] <= '0;
            end
            gpr[ESP_NUM] <= `GPR_RESET_ESP;
        end else if (wr.wb_en) begin
            gpr[wb_phys] <= merge(gpr[wb_phys], wr.wb_data, wr.wb_reg, wr.wb_size);
        end
    end

    // execute must never retire with the reserved size
    a_wb_size_legal: assert property (@(posedge clk) disable iff (!rst_n)
        wr.wb_en |-> wr.wb_size != 2'd3)
        else $error("writeback with reserved size code");

endmodule

`default_nettype wire

//--- x86_int_pipe.sv
/*
 * Top of the integer register pipeline. An issue pulse retires two
 * cycles later and its result is in the register file one edge after that.
 * No forwarding: dependent issues must be two cycles apart.
 */
`default_nettype none

module x86_int_pipe (
    input  logic                   clk,
    input  logic                   rst_n,

    // issue side, one-cycle strobe
    input  logic                   issue_valid,
    input  x86_regs_pkg::alu_op_t  issue_op,
    input  x86_regs_pkg::op_size_t issue_size,
    input  x86_regs_pkg::reg_num_t issue_dst,
    input  x86_regs_pkg::reg_num_t issue_src,
    input  x86_regs_pkg::reg_num_t issue_base,
    input  x86_regs_pkg::reg_num_t issue_index,
    input  x86_regs_pkg::scale_t   issue_scale,
    input  x86_regs_pkg::word_t    issue_disp,

    // retire side
    output logic                   retire_valid,
    output x86_regs_pkg::reg_num_t retire_dst,
    output x86_regs_pkg::op_size_t retire_size,
    output x86_regs_pkg::word_t    retire_value,
    output x86_regs_pkg::word_t    retire_addr,

    // full-width register peek
    input  x86_regs_pkg::reg_num_t dbg_reg,
    output x86_regs_pkg::word_t    dbg_value
);

    gpr_read_if  rd_if ();
    gpr_write_if wr_if ();
    exec_if      ex_if ();

    x86_operand_read operand_read_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_size  (issue_size),
        .issue_dst   (issue_dst),
        .issue_src   (issue_src),
        .issue_base  (issue_base),
        .issue_index (issue_index),
        .issue_scale (issue_scale),
        .issue_disp  (issue_disp),
        .rd          (rd_if.reader),
        .ex          (ex_if.producer)
    );

    x86_execute execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex           (ex_if.consumer),
        .wr           (wr_if.writer),
        .retire_valid (retire_valid),
        .retire_dst   (retire_dst),
        .retire_size  (retire_size),
        .retire_value (retire_value),
        .retire_addr  (retire_addr)
    );

    x86_gpr_file gpr_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd_if.file),
        .wr        (wr_if.file),
        .dbg_reg   (dbg_reg),
        .dbg_value (dbg_value)
    );

endmodule

`default_nettype wire

//--- x86_operand_read.sv
/*
 * First pipeline stage. Captures an issued instruction, then reads its
 * sized operands and SIB registers from the register file during the
 * following cycle and presents everything to execute.
 */
`default_nettype none

module x86_operand_read (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  x86_regs_pkg::alu_op_t  issue_op,
    input  x86_regs_pkg::op_size_t issue_size,
    input  x86_regs_pkg::reg_num_t issue_dst,
    input  x86_regs_pkg::reg_num_t issue_src,
    input  x86_regs_pkg::reg_num_t issue_base,
    input  x86_regs_pkg::reg_num_t issue_index,
    input  x86_regs_pkg::scale_t   issue_scale,
    input  x86_regs_pkg::word_t    issue_disp,
    gpr_read_if.reader             rd,
    exec_if.producer               ex
);
    import x86_regs_pkg::*;

    logic     valid_q;
    alu_op_t  op_q;
    op_size_t size_q;
    reg_num_t dst_q;
    reg_num_t src_q;
    reg_num_t base_q;
    reg_num_t index_q;
    scale_t   scale_q;
    word_t    disp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    // held fields, only meaningful while valid_q is set
    always_ff @(posedge clk) begin
        op_q    <= issue_op;
        size_q  <= issue_size;
        dst_q   <= issue_dst;
        src_q   <= issue_src;
        base_q  <= issue_base;
        index_q <= issue_index;
        scale_q <= issue_scale;
        disp_q  <= issue_disp;
    end

    // destination doubles as the first source operand
    assign rd.op1_reg   = dst_q;
    assign rd.op2_reg   = src_q;
    assign rd.read_size = size_q;
    assign rd.base_reg  = base_q;
    assign rd.index_reg = index_q;

    assign ex.valid  = valid_q;
    assign ex.alu_op = op_q;
    assign ex.dst    = dst_q;
    assign ex.size   = size_q;
    assign ex.scale  = scale_q;
    assign ex.disp   = disp_q;
    assign ex.op1    = rd.op1_value;
    assign ex.op2    = rd.op2_value;
    assign ex.base   = rd.base_value;
    assign ex.index  = rd.index_value;

    a_issue_size_legal: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> issue_size != 2'd3)
        else $error("issue with reserved size code");

endmodule

`default_nettype wire

//--- x86_regs_pkg.sv
/*
 * Vector types shared by the integer pipeline and its testbench.
 * Import inside a module body, or use scoped names in port lists.
 */
`default_nettype none

package x86_regs_pkg;

    // --------------------------------------------------
    // data path
    // --------------------------------------------------

    // register contents, operands, results and addresses
    typedef logic [31:0] word_t;

    // --------------------------------------------------
    // instruction fields
    // --------------------------------------------------

    // register number; at 8 bits, 4..7 name ah, ch, dh, bh
    typedef logic [2:0] reg_num_t;

    // 32, 16 or 8 bit operand size code
    typedef logic [1:0] op_size_t;

    // mov, add, sub or lea
    typedef logic [1:0] alu_op_t;

    // SIB scale, index is shifted left by 0..3
    typedef logic [1:0] scale_t;

endpackage

`default_nettype wire

//--- x86_stage_ifs.sv
/*
 * Interfaces between the pipeline stages and the register file:
 * operand reads, sized writeback, and the operand-read to execute hand-off.
 */
`default_nettype none

// --------------------------------------------------
// operand reads, read stage to register file
// --------------------------------------------------
interface gpr_read_if;
    import x86_regs_pkg::*;

    reg_num_t op1_reg;
    reg_num_t op2_reg;
    op_size_t read_size;
    reg_num_t base_reg;
    reg_num_t index_reg;

    // sized values come back zero extended
    word_t    op1_value;
    word_t    op2_value;
    word_t    base_value;
    word_t    index_value;

    modport reader (
        output op1_reg, op2_reg, read_size, base_reg, index_reg,
        input  op1_value, op2_value, base_value, index_value
    );

    modport file (
        input  op1_reg, op2_reg, read_size, base_reg, index_reg,
        output op1_value, op2_value, base_value, index_value
    );
endinterface

// --------------------------------------------------
// writeback, execute to register file
// --------------------------------------------------
interface gpr_write_if;
    import x86_regs_pkg::*;

    logic     wb_en;
    reg_num_t wb_reg;
    op_size_t wb_size;
    word_t    wb_data;

    modport writer (output wb_en, wb_reg, wb_size, wb_data);
    modport file   (input  wb_en, wb_reg, wb_size, wb_data);
endinterface

// --------------------------------------------------
// captured instruction and operands
// --------------------------------------------------
interface exec_if;
    import x86_regs_pkg::*;

    logic     valid;
    alu_op_t  alu_op;
    reg_num_t dst;
    op_size_t size;
    scale_t   scale;
    word_t    disp;
    word_t    op1;
    word_t    op2;
    word_t    base;
    word_t    index;

    modport producer (output valid, alu_op, dst, size, scale, disp, op1, op2, base, index);
    modport consumer (input  valid, alu_op, dst, size, scale, disp, op1, op2, base, index);
endinterface

`default_nettype wire
